// File: Bender.yml
package:
  name: afe_readout

sources:
  - files:
      - rtl/afe_pkg.sv
      - rtl/afe_l2_addrgen.sv
      - rtl/afe_word_format.sv
      - rtl/afe_flag_capture.sv
      - rtl/afe_flag_event_fsm.sv
      - rtl/afe_top.sv
  - target: test
    files:
      - test/tb_afe_top.sv

// File: rtl/afe_flag_capture.sv
// Flag record capture that holds the latest flagged word behind a valid/ready output
`timescale 1ns/100ps

module afe_flag_capture
  import afe_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      hit_i,
  input  logic [AFE_CHID_WIDTH-1:0] hit_chid_i,
  input  logic [AFE_FLAG_WIDTH-1:0] hit_flags_i,
  input  logic [L2_TRANS_SIZE-1:0]  hit_wr_ptr_i,

  input  logic                      flag_ready_i,
  output logic                      flag_valid_o,
  output logic [31:0]               flag_data_o,
  output logic                      flag_tf_o
);

  logic        valid_q;
  logic [31:0] data_q;
  logic [31:0] record;

  always_comb begin
    record = '0;
    record[FLAG_REC_CHID_LSB +: FLAG_REC_CHID_WIDTH] = FLAG_REC_CHID_WIDTH'(hit_chid_i);
    record[AFE_FLAG_LSB +: AFE_FLAG_WIDTH]           = hit_flags_i;
    record[0 +: L2_TRANS_SIZE]                       = hit_wr_ptr_i;
  end

  assign flag_tf_o = valid_q && flag_ready_i;

  // Latest hit wins, even over a record still waiting for ready
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (hit_i) begin
      valid_q <= 1'b1;
    end else if (flag_tf_o) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (hit_i) begin
      data_q <= record;
    end
  end

  assign flag_valid_o = valid_q;
  assign flag_data_o  = data_q;

endmodule

// File: rtl/afe_flag_event_fsm.sv
// Flag event FSM that pulses on the first handshake and counts the ones after it
`timescale 1ns/100ps

module afe_flag_event_fsm
  import afe_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      flag_tf_i,
  input  logic                      flag_clr_i,

  output logic                      flag_event_o,
  output logic [FLAG_CNT_WIDTH-1:0] flag_cnt_o
);

  typedef enum logic {
    IDLE,
    TRIGGERED
  } state_e;

  state_e                    state_q, state_n;
  logic                      event_q, event_n;
  logic [FLAG_CNT_WIDTH-1:0] cnt_q, cnt_n;

  always_comb begin
    state_n = state_q;
    event_n = 1'b0;
    cnt_n   = cnt_q;

    case (state_q)
      IDLE: begin
        if (flag_tf_i) begin
          event_n = 1'b1;
          cnt_n   = FLAG_CNT_WIDTH'(1);
          state_n = TRIGGERED;
        end
      end
      TRIGGERED: begin
        if (flag_clr_i && !flag_tf_i) begin
          cnt_n   = '0;
          state_n = IDLE;
        end else if (flag_clr_i) begin
          // Clear and handshake together start a new event
          event_n = 1'b1;
          cnt_n   = FLAG_CNT_WIDTH'(1);
        end else if (flag_tf_i) begin
          cnt_n = cnt_q + 1'b1; // wraps at the counter width
        end
      end
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      event_q <= 1'b0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_n;
      event_q <= event_n;
      cnt_q   <= cnt_n;
    end
  end

  assign flag_event_o = event_q;
  assign flag_cnt_o   = cnt_q;

endmodule

// File: rtl/afe_l2_addrgen.sv
// L2 address generator that counts the bytes of one channel and flags the end of a transfer
`timescale 1ns/100ps

module afe_l2_addrgen
  import afe_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  input  l2_ch_cfg_t  cfg_i,
  input  logic        clr_i,

  input  logic        transfer_valid_i,

  output l2_ch_stat_t stat_o,
  output logic        event_o
);

  logic                     active_q;
  logic [L2_AWIDTH-1:0]     curr_addr_q;
  logic [L2_TRANS_SIZE-1:0] wr_ptr_q;
  logic [L2_TRANS_SIZE-1:0] bytes_left_q;
  logic                     event_q;

  logic [L2_TRANS_SIZE-1:0] step;
  logic                     last_tf;
  logic                     load;

  // Bytes per sample follow the configured data size
  assign step = L2_TRANS_SIZE'(1) << cfg_i.datasize;

  // Last accepted word of the current transfer
  assign last_tf = active_q && transfer_valid_i && (bytes_left_q <= step);

  // First start after enable, or automatic restart in continuous mode
  assign load = (!active_q && cfg_i.en) || (last_tf && cfg_i.continuous);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q     <= 1'b0;
      curr_addr_q  <= '0;
      wr_ptr_q     <= '0;
      bytes_left_q <= '0;
      event_q      <= 1'b0;
    end else begin
      event_q <= last_tf && !clr_i;

      if (clr_i) begin
        active_q <= 1'b0;
      end else if (load) begin
        active_q     <= 1'b1;
        curr_addr_q  <= cfg_i.startaddr;
        wr_ptr_q     <= '0;
        bytes_left_q <= cfg_i.size;
      end else if (last_tf) begin
        active_q <= 1'b0;
      end else if (active_q && transfer_valid_i) begin
        curr_addr_q  <= curr_addr_q + L2_AWIDTH'(step);
        wr_ptr_q     <= wr_ptr_q + step;
        bytes_left_q <= bytes_left_q - step;
      end
    end
  end

  assign stat_o.curr_addr  = curr_addr_q;
  assign stat_o.wr_ptr     = wr_ptr_q;
  assign stat_o.bytes_left = bytes_left_q;
  assign stat_o.active     = active_q;

  assign event_o = event_q;

endmodule

// File: rtl/afe_pkg.sv
// AFE receiver package with word layout, L2 channel configuration and flag types
package afe_pkg;

  // Sample word layout
  localparam int AFE_DATA_WIDTH = 32;
  localparam int AFE_PL_WIDTH   = 16;
  localparam int AFE_FLAG_LSB   = 16;
  localparam int AFE_FLAG_WIDTH = 4;
  localparam int AFE_CHID_LSB   = 28;
  localparam int AFE_CHID_WIDTH = 3;

  // Unused bits between the flag field and the channel id
  localparam int AFE_SPARE_WIDTH = AFE_CHID_LSB - AFE_FLAG_LSB - AFE_FLAG_WIDTH;

  // L2 side
  localparam int L2_NUM_CHS    = 8;
  localparam int L2_AWIDTH     = 12;
  localparam int L2_TRANS_SIZE = 16;

  // Flag record and event counter
  localparam int FLAG_CNT_WIDTH      = 6;
  localparam int FLAG_REC_CHID_LSB   = 24;
  localparam int FLAG_REC_CHID_WIDTH = 4;

  // Field view of one sample word, MSB first
  typedef struct packed {
    logic                       rsvd;
    logic [AFE_CHID_WIDTH-1:0]  chid;
    logic [AFE_SPARE_WIDTH-1:0] spare;
    logic [AFE_FLAG_WIDTH-1:0]  flags;
    logic [AFE_PL_WIDTH-1:0]    payload;
  } afe_fields_t;

  // A sample word seen either as raw bits or as decoded fields
  typedef union packed {
    logic [AFE_DATA_WIDTH-1:0] raw;
    afe_fields_t               f;
  } afe_word_u;

  // Per-channel L2 configuration
  // datasize: 0 byte, 1 half word, 2 word
  typedef struct packed {
    logic [L2_AWIDTH-1:0]     startaddr;
    logic [L2_TRANS_SIZE-1:0] size;
    logic [1:0]               datasize;
    logic                     continuous;
    logic                     en;
  } l2_ch_cfg_t;

  // Per-channel L2 status
  typedef struct packed {
    logic [L2_AWIDTH-1:0]     curr_addr;
    logic [L2_TRANS_SIZE-1:0] wr_ptr;
    logic [L2_TRANS_SIZE-1:0] bytes_left;
    logic                     active;
  } l2_ch_stat_t;

  // Reformatting applied to the L2 data word
  typedef enum logic [1:0] {
    MASK_RAW      = 2'd0,
    MASK_PL_FLAGS = 2'd1,
    MASK_PL_ONLY  = 2'd2,
    MASK_SIGN_EXT = 2'd3
  } mask_mode_e;

  // Flag capture configuration
  typedef struct packed {
    logic                      en;
    logic [AFE_FLAG_WIDTH-1:0] mask;
  } flag_cfg_t;

endpackage

// File: rtl/afe_top.sv
// AFE receiver readout top level with eight L2 channel counters, formatter and flag path
`timescale 1ns/100ps

module afe_top
  import afe_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_ni,

  input  logic                              buff_rvalid_i,
  input  afe_word_u                         buff_rdata_i,

  input  l2_ch_cfg_t  [L2_NUM_CHS-1:0]      l2_cfg_i,
  input  logic        [L2_NUM_CHS-1:0]      l2_clr_i,
  input  mask_mode_e                        mask_mode_i,
  input  flag_cfg_t                         flag_cfg_i,
  input  logic                              flag_ready_i,
  input  logic                              flag_clr_i,

  output logic        [L2_AWIDTH-1:0]       l2_addr_o,
  output logic        [1:0]                 l2_size_o,
  output logic        [AFE_DATA_WIDTH-1:0]  l2_wdata_o,
  output logic        [L2_NUM_CHS-1:0]      l2_ch_event_o,

  output logic                              flag_valid_o,
  output logic        [31:0]                flag_data_o,
  output logic                              flag_event_o,
  output logic        [FLAG_CNT_WIDTH-1:0]  flag_cnt_o
);

  l2_ch_stat_t [L2_NUM_CHS-1:0]     l2_stat;
  logic        [L2_NUM_CHS-1:0]     tf_valid;
  logic                             flag_hit;
  logic        [AFE_CHID_WIDTH-1:0] hit_chid;
  logic        [AFE_FLAG_WIDTH-1:0] hit_flags;
  logic        [L2_TRANS_SIZE-1:0]  hit_wr_ptr;
  logic                             flag_tf;

  // One byte counter per L2 channel
  for (genvar i = 0; i < L2_NUM_CHS; i++) begin : gen_l2_ch
    afe_l2_addrgen u_l2_addrgen (
      .clk_i            ( clk_i            ),
      .rst_ni           ( rst_ni           ),
      .cfg_i            ( l2_cfg_i[i]      ),
      .clr_i            ( l2_clr_i[i]      ),
      .transfer_valid_i ( tf_valid[i]      ),
      .stat_o           ( l2_stat[i]       ),
      .event_o          ( l2_ch_event_o[i] )
    );
  end

  afe_word_format u_word_format (
    .buff_rvalid_i ( buff_rvalid_i ),
    .buff_rdata_i  ( buff_rdata_i  ),
    .mask_mode_i   ( mask_mode_i   ),
    .flag_cfg_i    ( flag_cfg_i    ),
    .l2_cfg_i      ( l2_cfg_i      ),
    .l2_stat_i     ( l2_stat       ),
    .tf_valid_o    ( tf_valid      ),
    .l2_addr_o     ( l2_addr_o     ),
    .l2_size_o     ( l2_size_o     ),
    .l2_wdata_o    ( l2_wdata_o    ),
    .flag_hit_o    ( flag_hit      ),
    .hit_chid_o    ( hit_chid      ),
    .hit_flags_o   ( hit_flags     ),
    .hit_wr_ptr_o  ( hit_wr_ptr    )
  );

  afe_flag_capture u_flag_capture (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .hit_i        ( flag_hit     ),
    .hit_chid_i   ( hit_chid     ),
    .hit_flags_i  ( hit_flags    ),
    .hit_wr_ptr_i ( hit_wr_ptr   ),
    .flag_ready_i ( flag_ready_i ),
    .flag_valid_o ( flag_valid_o ),
    .flag_data_o  ( flag_data_o  ),
    .flag_tf_o    ( flag_tf      )
  );

  afe_flag_event_fsm u_flag_event_fsm (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .flag_tf_i    ( flag_tf      ),
    .flag_clr_i   ( flag_clr_i   ),
    .flag_event_o ( flag_event_o ),
    .flag_cnt_o   ( flag_cnt_o   )
  );

endmodule

// File: rtl/afe_word_format.sv
// Sample word formatter that decodes fields, reformats data and steers the word to its channel
`timescale 1ns/100ps

module afe_word_format
  import afe_pkg::*;
(
  input  logic                                buff_rvalid_i,
  input  afe_word_u                           buff_rdata_i,

  input  mask_mode_e                          mask_mode_i,
  input  flag_cfg_t                           flag_cfg_i,
  input  l2_ch_cfg_t  [L2_NUM_CHS-1:0]        l2_cfg_i,
  input  l2_ch_stat_t [L2_NUM_CHS-1:0]        l2_stat_i,

  output logic        [L2_NUM_CHS-1:0]        tf_valid_o,
  output logic        [L2_AWIDTH-1:0]         l2_addr_o,
  output logic        [1:0]                   l2_size_o,
  output logic        [AFE_DATA_WIDTH-1:0]    l2_wdata_o,

  output logic                                flag_hit_o,
  output logic        [AFE_CHID_WIDTH-1:0]    hit_chid_o,
  output logic        [AFE_FLAG_WIDTH-1:0]    hit_flags_o,
  output logic        [L2_TRANS_SIZE-1:0]     hit_wr_ptr_o
);

  afe_fields_t               fields;
  logic [AFE_CHID_WIDTH-1:0] chid;
  afe_word_u                 l2_word;

  // Fields read as zero while no word is valid
  assign fields = buff_rvalid_i ? buff_rdata_i.f : '0;
  assign chid   = fields.chid;

  always_comb begin
    tf_valid_o = '0;
    if (buff_rvalid_i) begin
      tf_valid_o[chid] = 1'b1;
    end
  end

  assign l2_addr_o    = buff_rvalid_i ? l2_stat_i[chid].curr_addr : '0;
  assign l2_size_o    = buff_rvalid_i ? l2_cfg_i[chid].datasize : '0;
  assign hit_wr_ptr_o = l2_stat_i[chid].wr_ptr;
  assign hit_chid_o   = chid;
  assign hit_flags_o  = fields.flags;

  assign flag_hit_o = buff_rvalid_i && flag_cfg_i.en && |(fields.flags & flag_cfg_i.mask);

  always_comb begin
    l2_word.raw = '0;
    if (buff_rvalid_i) begin
      case (mask_mode_i)
        MASK_RAW: l2_word.raw = buff_rdata_i.raw;
        MASK_PL_FLAGS: begin
          l2_word.f.flags   = fields.flags;
          l2_word.f.payload = fields.payload;
        end
        MASK_PL_ONLY: l2_word.f.payload = fields.payload;
        // Payload sign-extended over the upper half
        MASK_SIGN_EXT: begin
          l2_word.raw = {{(AFE_DATA_WIDTH-AFE_PL_WIDTH){fields.payload[AFE_PL_WIDTH-1]}},
                         fields.payload};
        end
        default: l2_word.raw = buff_rdata_i.raw;
      endcase
    end
  end

  assign l2_wdata_o = l2_word.raw;

endmodule

// File: test/tb_afe_top.sv
// Testbench for the AFE readout top level with a reference model and output assertions
`timescale 1ns/100ps

module tb_afe_top
  import afe_pkg::*;
;

  logic                             clk_i;
  logic                             rst_ni;
  logic                             buff_rvalid_i;
  afe_word_u                        buff_rdata_i;
  l2_ch_cfg_t  [L2_NUM_CHS-1:0]     l2_cfg_i;
  logic        [L2_NUM_CHS-1:0]     l2_clr_i;
  mask_mode_e                       mask_mode_i;
  flag_cfg_t                        flag_cfg_i;
  logic                             flag_ready_i;
  logic                             flag_clr_i;
  logic        [L2_AWIDTH-1:0]      l2_addr_o;
  logic        [1:0]                l2_size_o;
  logic        [AFE_DATA_WIDTH-1:0] l2_wdata_o;
  logic        [L2_NUM_CHS-1:0]     l2_ch_event_o;
  logic                             flag_valid_o;
  logic        [31:0]               flag_data_o;
  logic                             flag_event_o;
  logic        [FLAG_CNT_WIDTH-1:0] flag_cnt_o;

  // Reference model state
  logic        m_active [8];
  logic [11:0] m_addr [8];
  logic [15:0] m_wp [8];
  logic [15:0] m_left [8];
  logic [7:0]  m_event;
  logic        m_fvalid;
  logic [31:0] m_fdata;
  logic        m_fevent;
  logic [5:0]  m_fcnt;
  logic        m_trig;

  integer seed;
  int     checks;
  int     errors;
  int     err_mark;

  afe_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] make_word(input int ch, input logic [3:0] flags,
                                            input logic [15:0] payload);
    return {1'b0, 3'(ch), 8'd0, flags, payload};
  endfunction

  // L2 word as each mask mode defines it
  function automatic logic [31:0] expected_wdata(input logic [31:0] w, input mask_mode_e mode);
    case (mode)
      MASK_PL_FLAGS: return {12'd0, w[19:16], w[15:0]};
      MASK_PL_ONLY:  return {16'd0, w[15:0]};
      MASK_SIGN_EXT: return {{16{w[15]}}, w[15:0]};
      default:       return w;
    endcase
  endfunction

  task automatic report_err(input string msg);
    $display("ERR %0t %s", $time, msg);
    errors++;
  endtask

  task automatic end_test(input string name);
    $display("test %s finished with %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  task automatic send_word(input logic [31:0] w);
    @(posedge clk_i);
    buff_rvalid_i <= 1'b1;
    buff_rdata_i  <= w;
  endtask

  task automatic idle_cycle();
    @(posedge clk_i);
    buff_rvalid_i <= 1'b0;
  endtask

  task automatic handshake(input logic with_clr);
    @(posedge clk_i);
    buff_rvalid_i <= 1'b0;
    flag_ready_i  <= 1'b1;
    flag_clr_i    <= with_clr;
    @(posedge clk_i);
    flag_ready_i  <= 1'b0;
    flag_clr_i    <= 1'b0;
  endtask

  task automatic wait_flag_valid();
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < 10) begin
      @(negedge clk_i);
      seen = flag_valid_o;
      n++;
    end
    if (!seen) begin
      $display("Timeout: flag_valid_o did not rise after a flagged word");
      errors++;
    end
  endtask

  task automatic wait_flag_event();
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < 10) begin
      @(negedge clk_i);
      seen = flag_event_o;
      n++;
    end
    if (!seen) begin
      $display("Timeout: flag_event_o did not pulse after a handshake");
      errors++;
    end
  endtask

  // Feeds words to one channel until its end-of-transfer event shows up
  task automatic run_to_event(input int ch);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < 40) begin
      send_word(make_word(ch, 4'h0, 16'($random(seed))));
      idle_cycle();
      @(negedge clk_i);
      seen = l2_ch_event_o[ch];
      n++;
    end
    if (!seen) begin
      $display("Timeout: channel %0d never signalled end of transfer", ch);
      errors++;
    end
  endtask

  always @(posedge clk_i or negedge rst_ni) begin : ref_model
    int          c;
    logic [15:0] step;
    logic        tf;
    logic        last;
    logic        hit;
    logic        hs;
    logic [2:0]  ch;
    if (!rst_ni) begin
      for (c = 0; c < 8; c++) begin
        m_active[c] <= 1'b0;
        m_addr[c]   <= '0;
        m_wp[c]     <= '0;
        m_left[c]   <= '0;
      end
      m_event  <= '0;
      m_fvalid <= 1'b0;
      m_fevent <= 1'b0;
      m_fcnt   <= '0;
      m_trig   <= 1'b0;
    end else begin
      ch = buff_rdata_i.raw[30:28];
      for (c = 0; c < 8; c++) begin
        step = 16'd1 << l2_cfg_i[c].datasize;
        tf   = buff_rvalid_i && (ch == 3'(c)) && m_active[c];
        last = tf && (m_left[c] <= step);
        m_event[c] <= last && !l2_clr_i[c];
        if (l2_clr_i[c]) begin
          m_active[c] <= 1'b0;
        end else if ((!m_active[c] && l2_cfg_i[c].en) || (last && l2_cfg_i[c].continuous)) begin
          m_active[c] <= 1'b1;
          m_addr[c]   <= l2_cfg_i[c].startaddr;
          m_wp[c]     <= '0;
          m_left[c]   <= l2_cfg_i[c].size;
        end else if (last) begin
          m_active[c] <= 1'b0;
        end else if (tf) begin
          m_addr[c] <= m_addr[c] + step[11:0];
          m_wp[c]   <= m_wp[c] + step;
          m_left[c] <= m_left[c] - step;
        end
      end
      // Flag record, newest hit wins
      hit = buff_rvalid_i && flag_cfg_i.en && |(buff_rdata_i.raw[19:16] & flag_cfg_i.mask);
      hs  = m_fvalid && flag_ready_i;
      if (hit) begin
        m_fvalid <= 1'b1;
        m_fdata  <= {4'h0, 1'b0, ch, 4'h0, buff_rdata_i.raw[19:16], m_wp[ch]};
      end else if (hs) begin
        m_fvalid <= 1'b0;
      end
      m_fevent <= 1'b0;
      if (!m_trig) begin
        if (hs) begin
          m_fevent <= 1'b1;
          m_fcnt   <= 6'd1;
          m_trig   <= 1'b1;
        end
      end else if (flag_clr_i && hs) begin
        m_fevent <= 1'b1;
        m_fcnt   <= 6'd1;
      end else if (flag_clr_i) begin
        m_fcnt <= '0;
        m_trig <= 1'b0;
      end else if (hs) begin
        m_fcnt <= m_fcnt + 6'd1;
      end
    end
  end

  // Outputs are compared in the middle of the cycle
  always @(negedge clk_i) begin : check_outputs
    logic [2:0] ch;
    ch = buff_rdata_i.raw[30:28];
    checks++;
    if (buff_rvalid_i) begin
      assert (l2_wdata_o === expected_wdata(buff_rdata_i.raw, mask_mode_i))
        else report_err($sformatf("l2_wdata_o %h expected %h", l2_wdata_o,
                                  expected_wdata(buff_rdata_i.raw, mask_mode_i)));
      assert (l2_addr_o === m_addr[ch])
        else report_err($sformatf("l2_addr_o %h expected %h", l2_addr_o, m_addr[ch]));
      assert (l2_size_o === l2_cfg_i[ch].datasize)
        else report_err($sformatf("l2_size_o %0d on channel %0d", l2_size_o, ch));
    end else begin
      assert ({l2_addr_o, l2_size_o, l2_wdata_o} === '0)
        else report_err("L2 outputs not zero without a valid word");
    end
    assert (l2_ch_event_o === m_event)
      else report_err($sformatf("l2_ch_event_o %b expected %b", l2_ch_event_o, m_event));
    assert (flag_valid_o === m_fvalid)
      else report_err($sformatf("flag_valid_o %b expected %b", flag_valid_o, m_fvalid));
    if (m_fvalid) begin
      assert (flag_data_o === m_fdata)
        else report_err($sformatf("flag_data_o %h expected %h", flag_data_o, m_fdata));
    end
    assert (flag_event_o === m_fevent)
      else report_err($sformatf("flag_event_o %b expected %b", flag_event_o, m_fevent));
    assert (flag_cnt_o === m_fcnt)
      else report_err($sformatf("flag_cnt_o %0d expected %0d", flag_cnt_o, m_fcnt));
  end

  initial begin
    seed          = 32'ha1ab8efb;
    checks        = 0;
    errors        = 0;
    err_mark      = 0;
    rst_ni        = 1'b0;
    buff_rvalid_i = 1'b0;
    buff_rdata_i  = '0;
    l2_clr_i      = '0;
    mask_mode_i   = MASK_RAW;
    flag_cfg_i    = '0;
    flag_ready_i  = 1'b0;
    flag_clr_i    = 1'b0;
    l2_cfg_i      = '0;
    l2_cfg_i[0] = '{startaddr: 12'h100, size: 16'd8, datasize: 2'd0, continuous: 1'b1, en: 1'b1};
    l2_cfg_i[1] = '{startaddr: 12'h200, size: 16'd8, datasize: 2'd1, continuous: 1'b0, en: 1'b1};
    l2_cfg_i[2] = '{startaddr: 12'h400, size: 16'd16, datasize: 2'd2, continuous: 1'b1, en: 1'b1};
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (3) idle_cycle();
    end_test("reset");

    for (int m = 0; m < 4; m++) begin
      @(posedge clk_i);
      mask_mode_i <= mask_mode_e'(m);
      for (int k = 0; k < 8; k++) begin
        send_word($random(seed));
      end
      idle_cycle();
    end
    end_test("format");

    // Restart every channel at its start address
    @(posedge clk_i);
    l2_clr_i <= '1;
    @(posedge clk_i);
    l2_clr_i <= '0;
    repeat (2) idle_cycle();
    for (int k = 0; k < 3; k++) begin
      send_word(make_word(0, 4'h0, 16'($random(seed))));
      send_word(make_word(1, 4'h0, 16'($random(seed))));
      send_word(make_word(2, 4'h0, 16'($random(seed))));
    end
    idle_cycle();
    end_test("address");

    run_to_event(0);
    send_word(make_word(0, 4'h0, 16'h1234));
    @(posedge clk_i);
    l2_cfg_i[1].en <= 1'b0;
    run_to_event(1);
    send_word(make_word(1, 4'h0, 16'h0001));
    send_word(make_word(1, 4'h0, 16'h0002));
    @(posedge clk_i);
    buff_rvalid_i  <= 1'b0;
    l2_cfg_i[1].en <= 1'b1;
    repeat (2) idle_cycle();
    send_word(make_word(1, 4'h0, 16'h0003));
    idle_cycle();
    end_test("end_of_transfer");

    @(posedge clk_i);
    flag_cfg_i <= '{en: 1'b1, mask: 4'b0101};
    send_word(make_word(0, 4'b0001, 16'h00aa));
    idle_cycle();
    wait_flag_valid();
    send_word(make_word(0, 4'b1010, 16'h00bb));
    send_word(make_word(2, 4'b0100, 16'h00cc));
    repeat (2) idle_cycle();
    end_test("flag_record");

    handshake(1'b0);
    wait_flag_event();
    for (int k = 0; k < 3; k++) begin
      send_word(make_word(k, 4'b0100, 16'($random(seed))));
      idle_cycle();
      handshake(1'b0);
    end
    send_word(make_word(2, 4'b0001, 16'h0f0f));
    idle_cycle();
    handshake(1'b1);
    wait_flag_event();
    @(posedge clk_i);
    flag_clr_i <= 1'b1;
    @(posedge clk_i);
    flag_clr_i <= 1'b0;
    repeat (2) idle_cycle();
    end_test("flag_event");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
rtl/afe_pkg.sv
rtl/afe_l2_addrgen.sv
rtl/afe_word_format.sv
rtl/afe_flag_capture.sv
rtl/afe_flag_event_fsm.sv
rtl/afe_top.sv
test/tb_afe_top.sv
